/* logic/rsa_defines.svh */
`ifndef RSA_DEFINES_SVH
`define RSA_DEFINES_SVH

// operand width in bits, 256 works as well
`define RSA_WIDTH 128

// entries per FIFO, power of two
`define RSA_FIFO_DEPTH 4

// bytes per operand on the serial input
`define RSA_BYTES (`RSA_WIDTH / 8)

`endif

/* logic/rsa_pkg.sv */
`include "rsa_defines.svh"

package rsa_pkg;

	typedef logic [3:0] rsa_tag_t; // wraps at 16

	typedef struct packed {
		logic [`RSA_WIDTH-1:0] n; // modulus, odd
		logic [`RSA_WIDTH-1:0] d; // private exponent
	} rsa_key_t;

	typedef struct packed {
		rsa_tag_t              tag;
		logic [`RSA_WIDTH-1:0] cipher;
	} rsa_job_t;

	typedef struct packed {
		rsa_tag_t              tag;
		logic [`RSA_WIDTH-1:0] plain;
	} rsa_result_t;

endpackage

/* logic/rsa_byte_loader.sv */
`include "rsa_defines.svh"

module rsa_byte_loader (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_key_load,
	input  logic              i_byte_valid,
	input  logic [7:0]        i_byte,
	output rsa_pkg::rsa_key_t o_key,
	output logic              o_job_push,
	output rsa_pkg::rsa_job_t o_job
);
	localparam int unsigned W = `RSA_WIDTH;
	localparam int unsigned CNT_W = $clog2(2 * `RSA_BYTES) + 1;
	localparam logic [CNT_W-1:0] HALF = CNT_W'(`RSA_BYTES);
	localparam logic [CNT_W-1:0] KEY_LAST = CNT_W'(2 * `RSA_BYTES - 1);
	localparam logic [CNT_W-1:0] CIPHER_LAST = CNT_W'(`RSA_BYTES - 1);

	logic              key_load_q;
	logic              mode_change;
	logic [CNT_W-1:0]  byte_cnt;
	logic [CNT_W-1:0]  byte_idx;
	logic [CNT_W-1:0]  last_idx;
	logic              key_byte;
	logic              cipher_byte;
	logic              cipher_done;
	logic              job_push_r;
	rsa_pkg::rsa_tag_t tag_r;
	rsa_pkg::rsa_key_t key_r;
	logic [W-1:0]      cipher_r;

	// a toggle of the key-load level restarts the operand
	assign mode_change = i_key_load ^ key_load_q;
	assign byte_idx = mode_change ? '0 : byte_cnt;
	assign last_idx = i_key_load ? KEY_LAST : CIPHER_LAST;

	assign key_byte = i_byte_valid && i_key_load;
	assign cipher_byte = i_byte_valid && !i_key_load;
	assign cipher_done = cipher_byte && (byte_idx == CIPHER_LAST);

	assign o_key = key_r;
	assign o_job_push = job_push_r;
	assign o_job = '{tag: tag_r, cipher: cipher_r};

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			key_load_q <= 1'b0;
			byte_cnt   <= '0;
			job_push_r <= 1'b0;
			tag_r      <= '0;
		end else begin
			key_load_q <= i_key_load;
			job_push_r <= cipher_done; // one cycle after the last byte
			if (i_byte_valid) begin
				byte_cnt <= (byte_idx == last_idx) ? '0 : byte_idx + 1'b1;
			end else if (mode_change) begin
				byte_cnt <= '0;
			end
			if (job_push_r) begin
				tag_r <= tag_r + 1'b1;
			end
		end
	end

	// msb first, so every byte shifts in at the bottom
	always_ff @(posedge i_clk) begin
		if (key_byte && (byte_idx < HALF)) begin
			key_r.n <= {key_r.n[W-9:0], i_byte};
		end
		if (key_byte && (byte_idx >= HALF)) begin
			key_r.d <= {key_r.d[W-9:0], i_byte};
		end
		if (cipher_byte) begin
			cipher_r <= {cipher_r[W-9:0], i_byte};
		end
	end

endmodule

/* logic/rsa_sync_fifo.sv */
`include "rsa_defines.svh"

module rsa_sync_fifo #(
	parameter type payload_t = logic
) (
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_push,
	input  payload_t i_data,
	input  logic     i_pop,
	output payload_t o_data,
	output logic     o_not_empty,
	output logic     o_full
);
	localparam int unsigned DEPTH = `RSA_FIFO_DEPTH;
	localparam int unsigned PTR_W = $clog2(DEPTH);
	localparam int unsigned CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = i_push && !o_full; // dropped when full
	assign do_pop = i_pop && o_not_empty;

	assign o_data = mem[rd_ptr]; // head shown directly
	assign o_not_empty = (count != '0);
	assign o_full = (count == FULL_COUNT);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

endmodule

/* logic/rsa_mont_mul.sv */
`include "rsa_defines.svh"

module rsa_mont_mul (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  logic [`RSA_WIDTH-1:0] i_mod,
	input  logic [`RSA_WIDTH-1:0] i_a,
	input  logic [`RSA_WIDTH-1:0] i_b,
	output logic                  o_done,
	output logic [`RSA_WIDTH-1:0] o_result
);
	localparam int unsigned W = `RSA_WIDTH;
	localparam int unsigned CNT_W = $clog2(W) + 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(W);

	logic             busy;
	logic             done_r;
	logic [CNT_W-1:0] iter;
	logic [W:0]       acc; // one extra bit for the carry
	logic [W-1:0]     a_sh;
	logic [W-1:0]     b_r;
	logic [W+1:0]     sum_ab;
	logic [W+1:0]     sum_n;
	logic             load;
	logic             step;
	logic             fold;

	assign load = i_start && !busy;
	assign step = busy && (iter != LAST);
	assign fold = busy && (iter == LAST); // final conditional subtract

	// acc stays below 2n, so W+2 bits hold acc + b + n
	assign sum_ab = {1'b0, acc} + (a_sh[0] ? {2'b00, b_r} : '0);
	assign sum_n = sum_ab[0] ? sum_ab + {2'b00, i_mod} : sum_ab; // clear the low bit

	assign o_done = done_r;
	assign o_result = acc[W-1:0];

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy   <= 1'b0;
			iter   <= '0;
			done_r <= 1'b0;
		end else begin
			done_r <= fold; // single cycle pulse
			if (load) begin
				busy <= 1'b1;
				iter <= '0;
			end else if (step) begin
				iter <= iter + 1'b1;
			end else if (fold) begin
				busy <= 1'b0;
			end
		end
	end

	// operands latched at start, a consumed lsb first
	always_ff @(posedge i_clk) begin
		if (load) begin
			acc  <= '0;
			a_sh <= i_a;
			b_r  <= i_b;
		end else if (step) begin
			acc  <= sum_n[W+1:1];
			a_sh <= a_sh >> 1;
		end else if (fold && (acc >= {1'b0, i_mod})) begin
			acc <= acc - {1'b0, i_mod};
		end
	end

endmodule

/* logic/rsa_modexp_core.sv */
`include "rsa_defines.svh"

module rsa_modexp_core (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  rsa_pkg::rsa_key_t    i_key,
	input  rsa_pkg::rsa_job_t    i_job,
	input  logic                 i_job_avail,
	input  logic                 i_result_full,
	output logic                 o_job_pop,
	output logic                 o_result_push,
	output rsa_pkg::rsa_result_t o_result
);
	localparam int unsigned W = `RSA_WIDTH;
	localparam int unsigned CNT_W = $clog2(W) + 1;
	localparam logic [CNT_W-1:0] PRESCALE_LAST = CNT_W'(W - 1);
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(W);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PRESCALE,
		S_BIT,
		S_MUL,
		S_SQR
	} state_t;

	state_t            state;
	logic [CNT_W-1:0]  iter; // prescale step, then exponent bit
	logic              held; // a popped job waits for result room
	rsa_pkg::rsa_job_t job_r;
	logic [W-1:0]      t_r;
	logic [W-1:0]      m_r;
	logic [W-1:0]      d_sh;
	logic [W:0]        t_dbl;
	logic              start_job;
	logic              last_bit;
	logic              mont_start;
	logic              mont_done;
	logic [W-1:0]      mont_a;
	logic [W-1:0]      mont_result;

	assign o_job_pop = (state == S_IDLE) && !held && i_job_avail;
	assign start_job = (state == S_IDLE) && held && !i_result_full;
	assign last_bit = (state == S_BIT) && (iter == BIT_END);

	assign o_result_push = last_bit;
	assign o_result = '{tag: job_r.tag, plain: m_r};

	assign t_dbl = {t_r, 1'b0};

	// multiply on a set bit, the square always follows
	assign mont_start = ((state == S_BIT) && !last_bit) || ((state == S_MUL) && mont_done);
	assign mont_a = ((state == S_BIT) && d_sh[0]) ? m_r : t_r;

	rsa_mont_mul i_rsa_mont_mul (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mont_start),
		.i_mod    (i_key.n),
		.i_a      (mont_a),
		.i_b      (t_r),
		.o_done   (mont_done),
		.o_result (mont_result)
	);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= S_IDLE;
			iter  <= '0;
			held  <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (o_job_pop) begin
						held <= 1'b1;
					end else if (start_job) begin
						held  <= 1'b0;
						state <= S_PRESCALE;
						iter  <= '0;
					end
				end
				S_PRESCALE: begin
					if (iter == PRESCALE_LAST) begin
						state <= S_BIT;
						iter  <= '0;
					end else begin
						iter <= iter + 1'b1;
					end
				end
				S_BIT: begin
					if (last_bit) state <= S_IDLE;
					else if (d_sh[0]) state <= S_MUL;
					else state <= S_SQR;
				end
				S_MUL: begin
					if (mont_done) state <= S_SQR;
				end
				S_SQR: begin
					if (mont_done) begin
						state <= S_BIT;
						iter  <= iter + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// t in montgomery form, m stays in normal form
	always_ff @(posedge i_clk) begin
		if (o_job_pop) begin
			job_r <= i_job;
		end
		if (start_job) begin
			t_r  <= job_r.cipher;
			m_r  <= W'(1);
			d_sh <= i_key.d;
		end
		if (state == S_PRESCALE) begin
			t_r <= (t_dbl >= {1'b0, i_key.n}) ? W'(t_dbl - {1'b0, i_key.n}) : t_dbl[W-1:0];
		end
		if ((state == S_MUL) && mont_done) begin
			m_r <= mont_result;
		end
		if ((state == S_SQR) && mont_done) begin
			t_r  <= mont_result;
			d_sh <= d_sh >> 1; // next exponent bit
		end
	end

endmodule

/* logic/rsa_decrypt_top.sv */
module rsa_decrypt_top (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_key_load,
	input  logic                 i_byte_valid,
	input  logic [7:0]           i_byte,
	input  logic                 i_result_pop,
	output logic                 o_job_room,
	output logic                 o_result_avail,
	output rsa_pkg::rsa_result_t o_result
);
	rsa_pkg::rsa_key_t    key;
	logic                 job_push;
	rsa_pkg::rsa_job_t    job_data;
	rsa_pkg::rsa_job_t    job_head;
	logic                 job_pop;
	logic                 job_avail;
	logic                 job_full;
	logic                 result_push;
	rsa_pkg::rsa_result_t result_data;
	logic                 result_full;

	assign o_job_room = ~job_full;

	rsa_byte_loader i_rsa_byte_loader (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_key_load   (i_key_load),
		.i_byte_valid (i_byte_valid),
		.i_byte       (i_byte),
		.o_key        (key),
		.o_job_push   (job_push),
		.o_job        (job_data)
	);

	rsa_sync_fifo #(.payload_t(rsa_pkg::rsa_job_t)) i_job_fifo (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_push      (job_push),
		.i_data      (job_data),
		.i_pop       (job_pop),
		.o_data      (job_head),
		.o_not_empty (job_avail),
		.o_full      (job_full)
	);

	rsa_modexp_core i_rsa_modexp_core (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_key         (key),
		.i_job         (job_head),
		.i_job_avail   (job_avail),
		.i_result_full (result_full),
		.o_job_pop     (job_pop),
		.o_result_push (result_push),
		.o_result      (result_data)
	);

	rsa_sync_fifo #(.payload_t(rsa_pkg::rsa_result_t)) i_result_fifo (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_push      (result_push),
		.i_data      (result_data),
		.i_pop       (i_result_pop),
		.o_data      (o_result),
		.o_not_empty (o_result_avail),
		.o_full      (result_full)
	);

endmodule

/* verif/rsa_asserts.sv */
module rsa_asserts (
	input logic                 i_clk,
	input logic                 i_rst,
	input logic                 i_mont_done,
	input logic                 i_job_push,
	input logic                 i_job_full,
	input logic                 i_result_push,
	input logic                 i_result_full,
	input logic                 i_result_pop,
	input logic                 i_result_avail,
	input rsa_pkg::rsa_result_t i_result
);
	// done is a single cycle pulse
	mont_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		i_mont_done |=> !i_mont_done) else $error("multiplier done high two cycles running");

	job_push_room: assert property (@(posedge i_clk) disable iff (i_rst)
		i_job_push |-> !i_job_full) else $error("push into the full job FIFO");
	result_push_room: assert property (@(posedge i_clk) disable iff (i_rst)
		i_result_push |-> !i_result_full) else $error("push into the full result FIFO");

	result_pop_data: assert property (@(posedge i_clk) disable iff (i_rst)
		i_result_pop |-> i_result_avail) else $error("pop from the empty result FIFO");

	result_known: assert property (@(posedge i_clk) disable iff (i_rst)
		i_result_avail |-> !$isunknown(i_result)) else $error("result unknown while available");

endmodule

/* verif/rsa_tb.sv */
`include "rsa_defines.svh"

module rsa_tb;
	localparam int unsigned W = `RSA_WIDTH;
	localparam int unsigned BYTES = `RSA_BYTES;
	localparam int unsigned DEPTH = `RSA_FIFO_DEPTH;
	localparam int unsigned JOB_CYCLES = 3 * W * (W + 4); // one job with margin
	localparam logic [W-1:0] TOP_BIT = {1'b1, {(W - 1){1'b0}}};
	// textbook keys 3233/2753 and 3127/2011 repeated across the width
	localparam logic [W-1:0] KEY1_N = TOP_BIT | {(W / 16){16'h0CA1}};
	localparam logic [W-1:0] KEY1_D = {(W / 16){16'h0AC1}};
	localparam logic [W-1:0] KEY2_N = TOP_BIT | {(W / 16){16'h0C37}};
	localparam logic [W-1:0] KEY2_D = {(W / 16){16'h07DB}};

	logic                 i_clk;
	logic                 i_rst;
	logic                 i_key_load;
	logic                 i_byte_valid;
	logic [7:0]           i_byte;
	logic                 i_result_pop;
	logic                 o_job_room;
	logic                 o_result_avail;
	rsa_pkg::rsa_result_t o_result;

	logic [31:0]          rng_state;
	logic [W-1:0]         key_n;
	logic [W-1:0]         key_d;
	rsa_pkg::rsa_tag_t    next_tag;
	rsa_pkg::rsa_result_t expect_q[$]; // results in push order

	rsa_decrypt_top i_rsa_decrypt_top (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_key_load     (i_key_load),
		.i_byte_valid   (i_byte_valid),
		.i_byte         (i_byte),
		.i_result_pop   (i_result_pop),
		.o_job_room     (o_job_room),
		.o_result_avail (o_result_avail),
		.o_result       (o_result)
	);

	bind rsa_decrypt_top rsa_asserts i_rsa_asserts (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_mont_done    (i_rsa_modexp_core.mont_done),
		.i_job_push     (job_push),
		.i_job_full     (job_full),
		.i_result_push  (result_push),
		.i_result_full  (result_full),
		.i_result_pop   (i_result_pop),
		.i_result_avail (o_result_avail),
		.i_result       (o_result)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// plain square and multiply on double width products
	function automatic logic [W-1:0] modpow(input logic [W-1:0] c, input logic [W-1:0] e,
			input logic [W-1:0] n);
		logic [2*W-1:0] n2;
		logic [2*W-1:0] acc;
		logic [2*W-1:0] sq;
		n2 = {{W{1'b0}}, n};
		acc = {{(2 * W - 1){1'b0}}, 1'b1};
		sq = {{W{1'b0}}, c} % n2;
		for (int i = 0; i < int'(W); i++) begin
			if (e[i]) acc = (acc * sq) % n2;
			sq = (sq * sq) % n2;
		end
		return acc[W-1:0];
	endfunction

	task automatic make_cipher(output logic [W-1:0] c);
		for (int i = 0; i < int'(W / 32); i++) begin
			rng_state = xorshift32(rng_state);
			c[i*32 +: 32] = rng_state;
		end
		c[W-1] = 1'b0; // keeps it below n
	endtask

	// msb first and valid left high for the caller to drop
	task automatic send_operand(input logic [W-1:0] value);
		for (int i = int'(BYTES) - 1; i >= 0; i--) begin
			@(posedge i_clk);
			i_byte_valid <= 1'b1;
			i_byte <= value[i*8 +: 8];
		end
	endtask

	task automatic load_key(input logic [W-1:0] n, input logic [W-1:0] d);
		@(posedge i_clk);
		i_key_load <= 1'b1;
		send_operand(n);
		send_operand(d);
		@(posedge i_clk);
		i_byte_valid <= 1'b0;
		i_key_load <= 1'b0;
		key_n = n;
		key_d = d;
	endtask

	task automatic wait_room(input string name);
		int unsigned waited;
		waited = 0;
		@(negedge i_clk);
		while (!o_job_room && waited < JOB_CYCLES) begin
			waited++;
			@(negedge i_clk);
		end
		if (!o_job_room) report_failure($sformatf("%s: job FIFO never had room", name));
	endtask

	task automatic send_cipher(input string name, input logic [W-1:0] c,
			input logic [W-1:0] plain);
		rsa_pkg::rsa_result_t exp_r;
		wait_room(name);
		send_operand(c);
		@(posedge i_clk);
		i_byte_valid <= 1'b0;
		repeat (2) @(posedge i_clk); // push lands and the full flag settles
		exp_r.tag = next_tag;
		exp_r.plain = plain;
		expect_q.push_back(exp_r);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic collect_result(input string name);
		rsa_pkg::rsa_result_t exp_r;
		int unsigned waited;
		waited = 0;
		@(negedge i_clk);
		while (!o_result_avail && waited < JOB_CYCLES) begin
			waited++;
			@(negedge i_clk);
		end
		if (!o_result_avail) begin
			report_failure($sformatf("%s: no result within %0d cycles", name, JOB_CYCLES));
		end
		exp_r = expect_q.pop_front();
		assert (o_result.tag == exp_r.tag) else report_failure($sformatf(
			"Mismatch in %s: expected tag %0d, actual %0d", name, exp_r.tag, o_result.tag));
		assert (o_result.plain == exp_r.plain) else report_failure($sformatf(
			"Mismatch in %s: expected %h, actual %h", name, exp_r.plain, o_result.plain));
		@(posedge i_clk);
		i_result_pop <= 1'b1;
		@(posedge i_clk);
		i_result_pop <= 1'b0;
	endtask

	task automatic hold_room(input string name, input logic level, input int unsigned cycles);
		for (int unsigned i = 0; i < cycles; i++) begin
			@(negedge i_clk);
			assert (o_job_room == level) else report_failure($sformatf(
				"Mismatch in %s: expected o_job_room %0b, actual %0b", name, level, o_job_room));
		end
	endtask

	task automatic reset_state();
		@(negedge i_clk);
		assert (!o_result_avail && o_job_room) else report_failure($sformatf(
			"Mismatch in reset_state: expected avail 0 room 1, actual avail %0b room %0b",
			o_result_avail, o_job_room));
	endtask

	task automatic single_decrypt();
		logic [W-1:0] c;
		load_key(KEY1_N, KEY1_D);
		make_cipher(c);
		send_cipher("single_decrypt", c, modpow(c, key_d, key_n));
		collect_result("single_decrypt");
	endtask

	task automatic stream_order();
		logic [W-1:0] c;
		for (int k = 0; k < 4; k++) begin
			make_cipher(c);
			send_cipher("stream_order", c, modpow(c, key_d, key_n));
		end
		while (expect_q.size() != 0) collect_result("stream_order");
	endtask

	// result FIFO, the held job and the job FIFO fill in that order
	task automatic backpressure();
		logic [W-1:0] c;
		for (int k = 0; k < int'(2 * DEPTH); k++) begin
			make_cipher(c);
			send_cipher("backpressure", c, modpow(c, key_d, key_n));
		end
		wait_room("backpressure"); // core pops one more job and stalls on the result FIFO
		hold_room("backpressure", 1'b1, JOB_CYCLES);
		make_cipher(c);
		send_cipher("backpressure", c, modpow(c, key_d, key_n));
		hold_room("backpressure", 1'b0, JOB_CYCLES);
		while (expect_q.size() != 0) collect_result("backpressure");
		@(negedge i_clk);
		assert (!o_result_avail) else report_failure("backpressure: extra result after draining");
	endtask

	task automatic key_reload();
		logic [W-1:0] c;
		load_key(KEY2_N, KEY2_D);
		make_cipher(c);
		send_cipher("key_reload", c, modpow(c, key_d, key_n));
		collect_result("key_reload");
	endtask

	task automatic edge_values();
		logic [W-1:0] c;
		load_key(KEY2_N, {{(W - 1){1'b0}}, 1'b1});
		make_cipher(c);
		send_cipher("edge_values", c, c);
		collect_result("edge_values");
		load_key(KEY2_N, KEY2_D);
		send_cipher("edge_values", '0, '0);
		send_cipher("edge_values", {{(W - 1){1'b0}}, 1'b1}, {{(W - 1){1'b0}}, 1'b1});
		while (expect_q.size() != 0) collect_result("edge_values");
	endtask

	initial begin
		rng_state = 32'h4415_78a2;
		next_tag = '0;
		i_rst = 1'b1;
		i_key_load = 1'b0;
		i_byte_valid = 1'b0;
		i_byte = 8'h00;
		i_result_pop = 1'b0;
		repeat (10) @(posedge i_clk);
		i_rst <= 1'b0;
		reset_state();
		single_decrypt();
		stream_order();
		backpressure();
		key_reload();
		edge_values();
		$display("Test OK");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+logic
logic/rsa_pkg.sv
logic/rsa_byte_loader.sv
logic/rsa_sync_fifo.sv
logic/rsa_mont_mul.sv
logic/rsa_modexp_core.sv
logic/rsa_decrypt_top.sv
verif/rsa_asserts.sv
verif/rsa_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rsa_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
